/* hdl/data_mem.sv */
`timescale 1ns/100ps

module data_mem #(
	parameter int MEM_WORDS_LOG2 = 8,
	parameter int MEM_LATENCY    = 4
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            mem_req,
	input  logic            mem_write,
	input  lvp_pkg::addr_t  mem_addr,
	input  lvp_pkg::word_t  mem_wdata,
	output logic            mem_rvalid,
	output lvp_pkg::word_t  mem_rdata
);

	import lvp_pkg::*;

	localparam int WORDS = 2 ** MEM_WORDS_LOG2;

	word_t mem [WORDS];

	// delay line for the returned word
	logic [MEM_LATENCY-1:0] valid_pipe;
	word_t                  data_pipe [MEM_LATENCY];

	logic [MEM_WORDS_LOG2-1:0] word_idx;
	word_t                     access_data;

	// byte address to word index
	assign word_idx = mem_addr[MEM_WORDS_LOG2+1:2];

	// a write returns the stored word, a read the current contents
	assign access_data = mem_write ? mem_wdata : mem[word_idx];

	// known contents, word i holds 3*i
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = word_t'(i * 3);
		end
	end

	// array access happens at request time
	always_ff @(posedge clk) begin
		if (mem_req && mem_write) begin
			mem[word_idx] <= mem_wdata;
		end
	end

	// valid flags of the pipeline
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[MEM_LATENCY-2:0], mem_req};
		end
	end

	// data follows the flags
	always_ff @(posedge clk) begin
		data_pipe[0] <= access_data;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign mem_rvalid = valid_pipe[MEM_LATENCY-1];
	assign mem_rdata  = data_pipe[MEM_LATENCY-1];

	// every return matches a request exactly MEM_LATENCY cycles back
	a_rvalid_has_req: assert property (
		@(posedge clk) disable iff (!arst_n) mem_rvalid |-> $past(mem_req, MEM_LATENCY)
	);

endmodule

/* hdl/load_value_predictor.sv */
`timescale 1ns/100ps

module load_value_predictor (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            req_valid,
	input  logic            req_write,
	input  lvp_pkg::pc_t    req_pc,
	input  lvp_pkg::addr_t  req_addr,
	input  lvp_pkg::word_t  req_wdata,
	output logic            req_ready,
	output logic            spec_valid,
	output lvp_pkg::word_t  spec_data,
	output logic            resp_valid,
	input  logic            resp_ready,
	output lvp_pkg::word_t  resp_data,
	output logic            resp_confirm,
	output logic            resp_recover,
	output logic            lu_en,
	output lvp_pkg::pc_t    lu_pc,
	input  logic            lu_hit,
	input  lvp_pkg::word_t  lu_value,
	input  lvp_pkg::conf_t  lu_conf,
	output logic            upd_en,
	output lvp_pkg::pc_t    upd_pc,
	output lvp_pkg::word_t  upd_value,
	output logic            mem_req,
	output logic            mem_write,
	output lvp_pkg::addr_t  mem_addr,
	output lvp_pkg::word_t  mem_wdata,
	input  logic            mem_rvalid,
	input  lvp_pkg::word_t  mem_rdata,
	input  logic            pred_enable,
	input  lvp_pkg::conf_t  pred_threshold,
	output logic            stat_pred,
	output logic            stat_miss
);

	import lvp_pkg::*;

	lvp_state_t state;
	lvp_state_t state_d;

	// latched request
	logic  write_q;
	pc_t   pc_q;
	word_t wdata_q;

	// what was speculated for this load
	logic  spec_taken_q;
	word_t spec_value_q;

	logic req_fire;
	logic resp_fire;
	logic mem_done;
	logic spec_match;

	assign req_ready = (state == IDLE);
	assign req_fire  = req_valid && req_ready;
	assign resp_valid = (state == RESPOND);
	assign resp_fire  = resp_valid && resp_ready;
	assign mem_done   = (state == WAIT_MEM) && mem_rvalid;

	// table lookup and memory access both go out in the accept cycle
	assign lu_en     = req_fire;
	assign lu_pc     = req_pc;
	assign mem_req   = req_fire;
	assign mem_write = req_write;
	assign mem_addr  = req_addr;
	assign mem_wdata = req_wdata;

	// speculate on a confident hit of a load
	assign spec_valid = (state == LOOKUP) && pred_enable && !write_q && lu_hit &&
		(lu_conf >= pred_threshold);
	assign spec_data  = lu_value;
	assign stat_pred  = spec_valid;

	// memory word against the speculated one
	assign spec_match = (mem_rdata == spec_value_q);
	assign stat_miss  = mem_done && spec_taken_q && !spec_match;

	// commit the architectural value once the core takes it
	assign upd_en    = resp_fire && !write_q;
	assign upd_pc    = pc_q;
	assign upd_value = resp_data;

	// next state
	always_comb begin
		state_d = state;
		case (state)
			IDLE:     if (req_fire) state_d = LOOKUP;
			LOOKUP:   state_d = WAIT_MEM;
			WAIT_MEM: if (mem_rvalid) state_d = RESPOND;
			RESPOND:  if (resp_ready) state_d = IDLE;
			default:  state_d = IDLE;
		endcase
	end

	// control state and response flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= IDLE;
			write_q      <= 1'b0;
			spec_taken_q <= 1'b0;
			resp_confirm <= 1'b0;
			resp_recover <= 1'b0;
		end else begin
			state <= state_d;
			if (req_fire) begin
				write_q <= req_write;
			end
			if (state == LOOKUP) begin
				spec_taken_q <= spec_valid;
			end
			if (mem_done) begin
				resp_confirm <= spec_taken_q && spec_match;
				resp_recover <= spec_taken_q && !spec_match;
			end else if (resp_fire) begin
				resp_confirm <= 1'b0;
				resp_recover <= 1'b0;
			end
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (req_fire) begin
			pc_q    <= req_pc;
			wdata_q <= req_wdata;
		end
		if (state == LOOKUP) begin
			spec_value_q <= lu_value;
		end
		// stores answer with their own data
		if (mem_done) begin
			resp_data <= write_q ? wdata_q : mem_rdata;
		end
	end

	// speculation only in the cycle right after an accept
	a_spec_after_accept: assert property (
		@(posedge clk) disable iff (!arst_n) spec_valid |-> $past(req_valid && req_ready)
	);

	// confirm or recover only on a load response and never both
	a_flags_on_load_resp: assert property (
		@(posedge clk) disable iff (!arst_n)
		(resp_confirm || resp_recover) |-> resp_valid && !write_q &&
			(resp_confirm != resp_recover)
	);

	// response held under back-pressure
	a_resp_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) &&
			$stable(resp_confirm) && $stable(resp_recover)
	);

endmodule

/* hdl/lvp_config.sv */
`timescale 1ns/100ps

module lvp_config (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                cfg_we,
	input  lvp_pkg::cfg_addr_t  cfg_addr,
	input  lvp_pkg::word_t      cfg_wdata,
	input  logic                stat_pred,
	input  logic                stat_miss,
	output lvp_pkg::word_t      cfg_rdata,
	output logic                pred_enable,
	output lvp_pkg::conf_t      pred_threshold
);

	import lvp_pkg::*;

	count_t npred_q;
	count_t nmiss_q;

	// enable and threshold registers
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pred_enable    <= 1'b0;
			pred_threshold <= THRESH_RESET;
		end else if (cfg_we) begin
			if (cfg_addr == CFG_CTRL) begin
				pred_enable <= cfg_wdata[0];
			end
			if (cfg_addr == CFG_THRESH) begin
				pred_threshold <= cfg_wdata[1:0];
			end
		end
	end

	// statistics, a write clears and wins over a count
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			npred_q <= '0;
			nmiss_q <= '0;
		end else begin
			if (cfg_we && cfg_addr == CFG_NPRED) begin
				npred_q <= '0;
			end else if (stat_pred && npred_q != '1) begin
				npred_q <= npred_q + 1'b1;
			end
			if (cfg_we && cfg_addr == CFG_NMISS) begin
				nmiss_q <= '0;
			end else if (stat_miss && nmiss_q != '1) begin
				nmiss_q <= nmiss_q + 1'b1;
			end
		end
	end

	// read mux, zero extended
	always_comb begin
		case (cfg_addr)
			CFG_CTRL:   cfg_rdata = word_t'(pred_enable);
			CFG_THRESH: cfg_rdata = word_t'(pred_threshold);
			CFG_NPRED:  cfg_rdata = word_t'(npred_q);
			default:    cfg_rdata = word_t'(nmiss_q);
		endcase
	end

endmodule

/* hdl/lvp_pkg.sv */
package lvp_pkg;

	// one data word as seen by the core and the memory
	typedef logic [31:0] word_t;

	// byte address, memory decodes only the word index
	typedef logic [31:0] addr_t;

	// program counter of a load
	typedef logic [31:0] pc_t;

	// saturating confidence, 0 = just replaced, 3 = strongest
	typedef logic [1:0] conf_t;

	// statistics counter width
	typedef logic [15:0] count_t;

	// config register address
	typedef logic [1:0] cfg_addr_t;

	// config register map
	// bit 0 of CTRL is the prediction enable
	localparam cfg_addr_t CFG_CTRL   = 2'd0;
	// minimum confidence needed to speculate
	localparam cfg_addr_t CFG_THRESH = 2'd1;
	// issued predictions, any write clears
	localparam cfg_addr_t CFG_NPRED  = 2'd2;
	// mispredictions that raised a recover, any write clears
	localparam cfg_addr_t CFG_NMISS  = 2'd3;

	// threshold value out of reset
	localparam conf_t THRESH_RESET = 2'd2;

	// control FSM of the predictor
	// IDLE      ready for a request
	// LOOKUP    table data back, speculation decided
	// WAIT_MEM  waiting for the memory word
	// RESPOND   response held until accepted
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		WAIT_MEM,
		RESPOND
	} lvp_state_t;

endpackage

/* hdl/lvp_table.sv */
`timescale 1ns/100ps

module lvp_table #(
	parameter int INDEX_WIDTH = 6
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            lu_en,
	input  lvp_pkg::pc_t    lu_pc,
	input  logic            upd_en,
	input  lvp_pkg::pc_t    upd_pc,
	input  lvp_pkg::word_t  upd_value,
	output logic            lu_hit,
	output lvp_pkg::word_t  lu_value,
	output lvp_pkg::conf_t  lu_conf
);

	import lvp_pkg::*;

	localparam int DEPTH = 2 ** INDEX_WIDTH;

	// per entry state
	word_t              value_mem [DEPTH];
	logic [DEPTH-1:0]   valid_q;
	conf_t              conf_q [DEPTH];

	logic [INDEX_WIDTH-1:0] lu_idx;
	logic [INDEX_WIDTH-1:0] upd_idx;
	logic                   upd_same;

	// direct mapped on the pc word bits, no tag
	assign lu_idx  = lu_pc[INDEX_WIDTH+1:2];
	assign upd_idx = upd_pc[INDEX_WIDTH+1:2];

	// committed value repeats what the entry already holds
	assign upd_same = valid_q[upd_idx] && (value_mem[upd_idx] == upd_value);

	// registered lookup, result held until the next lookup
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lu_hit  <= 1'b0;
			lu_conf <= '0;
		end else if (lu_en) begin
			lu_hit  <= valid_q[lu_idx];
			lu_conf <= conf_q[lu_idx];
		end
	end

	// value read path
	always_ff @(posedge clk) begin
		if (lu_en) begin
			lu_value <= value_mem[lu_idx];
		end
	end

	// valid bits and confidence counters
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				conf_q[i] <= '0;
			end
		end else if (upd_en) begin
			valid_q[upd_idx] <= 1'b1;
			if (upd_same) begin
				// saturate at 3
				if (conf_q[upd_idx] != 2'd3) begin
					conf_q[upd_idx] <= conf_q[upd_idx] + 2'd1;
				end
			end else begin
				// new value starts with no confidence
				conf_q[upd_idx] <= '0;
			end
		end
	end

	// value storage, rewritten only on a change
	always_ff @(posedge clk) begin
		if (upd_en && !upd_same) begin
			value_mem[upd_idx] <= upd_value;
		end
	end

	// lookup belongs to IDLE, commit to RESPOND of the predictor
	a_no_lookup_during_commit: assert property (
		@(posedge clk) disable iff (!arst_n) !(lu_en && upd_en)
	);

endmodule

/* hdl/lvp_top.sv */
`timescale 1ns/100ps

module lvp_top #(
	parameter int INDEX_WIDTH    = 6,
	parameter int MEM_WORDS_LOG2 = 8,
	parameter int MEM_LATENCY    = 4
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,
	input  logic                req_write,
	input  lvp_pkg::pc_t        req_pc,
	input  lvp_pkg::addr_t      req_addr,
	input  lvp_pkg::word_t      req_wdata,
	output logic                req_ready,
	output logic                spec_valid,
	output lvp_pkg::word_t      spec_data,
	output logic                resp_valid,
	input  logic                resp_ready,
	output lvp_pkg::word_t      resp_data,
	output logic                resp_confirm,
	output logic                resp_recover,
	input  logic                cfg_we,
	input  lvp_pkg::cfg_addr_t  cfg_addr,
	input  lvp_pkg::word_t      cfg_wdata,
	output lvp_pkg::word_t      cfg_rdata
);

	import lvp_pkg::*;

	// predictor to table
	logic  lu_en;
	pc_t   lu_pc;
	logic  lu_hit;
	word_t lu_value;
	conf_t lu_conf;
	logic  upd_en;
	pc_t   upd_pc;
	word_t upd_value;

	// predictor to memory
	logic  mem_req;
	logic  mem_write;
	addr_t mem_addr;
	word_t mem_wdata;
	logic  mem_rvalid;
	word_t mem_rdata;

	// predictor to config
	logic  pred_enable;
	conf_t pred_threshold;
	logic  stat_pred;
	logic  stat_miss;

	load_value_predictor u_ctrl (
		.clk            (clk),
		.arst_n         (arst_n),
		.req_valid      (req_valid),
		.req_write      (req_write),
		.req_pc         (req_pc),
		.req_addr       (req_addr),
		.req_wdata      (req_wdata),
		.req_ready      (req_ready),
		.spec_valid     (spec_valid),
		.spec_data      (spec_data),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp_data      (resp_data),
		.resp_confirm   (resp_confirm),
		.resp_recover   (resp_recover),
		.lu_en          (lu_en),
		.lu_pc          (lu_pc),
		.lu_hit         (lu_hit),
		.lu_value       (lu_value),
		.lu_conf        (lu_conf),
		.upd_en         (upd_en),
		.upd_pc         (upd_pc),
		.upd_value      (upd_value),
		.mem_req        (mem_req),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_rvalid     (mem_rvalid),
		.mem_rdata      (mem_rdata),
		.pred_enable    (pred_enable),
		.pred_threshold (pred_threshold),
		.stat_pred      (stat_pred),
		.stat_miss      (stat_miss)
	);

	lvp_table #(
		.INDEX_WIDTH (INDEX_WIDTH)
	) u_table (
		.clk       (clk),
		.arst_n    (arst_n),
		.lu_en     (lu_en),
		.lu_pc     (lu_pc),
		.upd_en    (upd_en),
		.upd_pc    (upd_pc),
		.upd_value (upd_value),
		.lu_hit    (lu_hit),
		.lu_value  (lu_value),
		.lu_conf   (lu_conf)
	);

	lvp_config u_config (
		.clk            (clk),
		.arst_n         (arst_n),
		.cfg_we         (cfg_we),
		.cfg_addr       (cfg_addr),
		.cfg_wdata      (cfg_wdata),
		.stat_pred      (stat_pred),
		.stat_miss      (stat_miss),
		.cfg_rdata      (cfg_rdata),
		.pred_enable    (pred_enable),
		.pred_threshold (pred_threshold)
	);

	data_mem #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
		.MEM_LATENCY    (MEM_LATENCY)
	) u_mem (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_req    (mem_req),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and keep the output in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_lvp -f tb.f -o tb_lvp_sim \
	&& ./obj_dir/tb_lvp_sim > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
# the run passes only if the pass line is in the log
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb.f */
hdl/lvp_pkg.sv
hdl/lvp_table.sv
hdl/lvp_config.sv
hdl/data_mem.sv
hdl/load_value_predictor.sv
hdl/lvp_top.sv
testbench/tb_lvp.sv

/* testbench/tb_lvp.sv */
`timescale 1ns/100ps

module tb_lvp;

	import lvp_pkg::*;

	localparam int INDEX_WIDTH    = 6;
	localparam int MEM_WORDS_LOG2 = 8;
	localparam int MEM_LATENCY    = 4;
	localparam int CLK_HALF       = 4;
	// 700 requests, each well below MEM_LATENCY + 8 cycles
	localparam int WATCHDOG_CYCLES = 700 * (MEM_LATENCY + 8);

	logic      clk;
	logic      arst_n;
	logic      req_valid;
	logic      req_write;
	pc_t       req_pc;
	addr_t     req_addr;
	word_t     req_wdata;
	logic      req_ready;
	logic      spec_valid;
	word_t     spec_data;
	logic      resp_valid;
	logic      resp_ready;
	word_t     resp_data;
	logic      resp_confirm;
	logic      resp_recover;
	logic      cfg_we;
	cfg_addr_t cfg_addr;
	word_t     cfg_wdata;
	word_t     cfg_rdata;

	// reference model state
	word_t  model_mem [2 ** MEM_WORDS_LOG2];
	word_t  tab_value [2 ** INDEX_WIDTH];
	logic   tab_valid [2 ** INDEX_WIDTH];
	conf_t  tab_conf [2 ** INDEX_WIDTH];
	count_t n_pred;
	count_t n_miss;
	logic   model_enable;
	conf_t  model_thresh;

	logic [31:0] lfsr_q = 32'h1ee0_f2e0;

	lvp_top #(
		.INDEX_WIDTH    (INDEX_WIDTH),
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
		.MEM_LATENCY    (MEM_LATENCY)
	) uut (
		.clk          (clk),
		.arst_n       (arst_n),
		.req_valid    (req_valid),
		.req_write    (req_write),
		.req_pc       (req_pc),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.req_ready    (req_ready),
		.spec_valid   (spec_valid),
		.spec_data    (spec_data),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.resp_data    (resp_data),
		.resp_confirm (resp_confirm),
		.resp_recover (resp_recover),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	// all response fields, sampled at a clock edge
	task automatic check_response(input word_t data, input logic confirm, input logic recover);
		check_value("resp_valid", word_t'(resp_valid), 32'd1);
		check_value("resp_data", resp_data, data);
		check_value("resp_confirm", word_t'(resp_confirm), word_t'(confirm));
		check_value("resp_recover", word_t'(resp_recover), word_t'(recover));
	endtask

	// called right after a rising edge, returns right after one
	task automatic cfg_write(input cfg_addr_t a, input word_t d);
		cfg_we    <= 1'b1;
		cfg_addr  <= a;
		cfg_wdata <= d;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic cfg_expect(input cfg_addr_t a, input word_t exp, input string name);
		cfg_addr <= a;
		@(posedge clk);
		check_value(name, cfg_rdata, exp);
	endtask

	task automatic check_counters();
		cfg_expect(CFG_NPRED, word_t'(n_pred), "cfg_rdata NPRED");
		cfg_expect(CFG_NMISS, word_t'(n_miss), "cfg_rdata NMISS");
	endtask

	// last value rule, same value builds confidence
	task automatic commit_model(input int idx, input word_t v);
		if (tab_valid[idx] && tab_value[idx] == v) begin
			if (tab_conf[idx] != 2'd3) begin
				tab_conf[idx] = tab_conf[idx] + 2'd1;
			end
		end else begin
			tab_value[idx] = v;
			tab_conf[idx]  = 2'd0;
			tab_valid[idx] = 1'b1;
		end
	endtask

	task automatic run_request(input logic write, input pc_t pc, input addr_t addr,
		input word_t wdata);
		int    idx;
		int    widx;
		int    waited;
		int    stall;
		logic  exp_spec;
		logic  exp_confirm;
		logic  exp_recover;
		word_t exp_data;
		idx         = int'(pc[INDEX_WIDTH+1:2]);
		widx        = int'(addr[MEM_WORDS_LOG2+1:2]);
		exp_spec    = model_enable && !write && tab_valid[idx] &&
			(tab_conf[idx] >= model_thresh);
		exp_data    = write ? wdata : model_mem[widx];
		exp_confirm = exp_spec && (tab_value[idx] == exp_data);
		exp_recover = exp_spec && (tab_value[idx] != exp_data);
		stall       = int'(take_bits(2));
		if (write) begin
			model_mem[widx] = wdata;
		end
		req_valid <= 1'b1;
		req_write <= write;
		req_pc    <= pc;
		req_addr  <= addr;
		req_wdata <= wdata;
		// wait for the accept edge
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > 8) begin
				stop_with_failure("request was never accepted, req_ready stayed low");
			end
		end while (!req_ready);
		req_valid <= 1'b0;
		// speculation belongs to the first cycle after accept
		@(posedge clk);
		check_value("spec_valid", word_t'(spec_valid), word_t'(exp_spec));
		if (exp_spec) begin
			check_value("spec_data", spec_data, tab_value[idx]);
		end
		waited = 1;
		while (!resp_valid) begin
			@(posedge clk);
			waited++;
			if (waited > MEM_LATENCY + 1) begin
				stop_with_failure("resp_valid did not rise after the memory latency");
			end
		end
		check_value("resp latency", 32'(waited), 32'(MEM_LATENCY + 1));
		check_response(exp_data, exp_confirm, exp_recover);
		// back-pressure, fields must hold
		repeat (stall) begin
			@(posedge clk);
			check_response(exp_data, exp_confirm, exp_recover);
		end
		resp_ready <= 1'b1;
		@(posedge clk);
		check_response(exp_data, exp_confirm, exp_recover);
		resp_ready <= 1'b0;
		// handshake done, update model
		if (!write) begin
			commit_model(idx, exp_data);
		end
		if (exp_spec) begin
			n_pred = n_pred + 16'd1;
		end
		if (exp_recover) begin
			n_miss = n_miss + 16'd1;
		end
	endtask

	task automatic run_phase(input int count);
		int    pc_sel;
		int    alt;
		logic  is_store;
		word_t wdata;
		pc_t   pc;
		addr_t addr;
		for (int n = 0; n < count; n++) begin
			pc_sel   = int'(take_bits(2));
			// second address of a pc, 1 in 4
			alt      = (take_bits(2) == 32'd3) ? 1 : 0;
			is_store = (take_bits(2) == 32'd0);
			wdata    = take_bits(32);
			pc       = 32'h0000_2040 + pc_t'(pc_sel * 4);
			addr     = addr_t'((16 + pc_sel * 2 + alt) * 4);
			run_request(is_store, pc, addr, wdata);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_failure("watchdog expired before all requests finished");
	end

	initial begin
		arst_n     <= 1'b0;
		req_valid  <= 1'b0;
		req_write  <= 1'b0;
		req_pc     <= '0;
		req_addr   <= '0;
		req_wdata  <= '0;
		resp_ready <= 1'b0;
		cfg_we     <= 1'b0;
		cfg_addr   <= '0;
		cfg_wdata  <= '0;
		// model out of reset, memory word i holds 3*i
		for (int i = 0; i < 2 ** MEM_WORDS_LOG2; i++) begin
			model_mem[i] = word_t'(i * 3);
		end
		for (int i = 0; i < 2 ** INDEX_WIDTH; i++) begin
			tab_value[i] = '0;
			tab_valid[i] = 1'b0;
			tab_conf[i]  = '0;
		end
		n_pred       = '0;
		n_miss       = '0;
		model_enable = 1'b0;
		model_thresh = 2'd2;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		check_value("req_ready", word_t'(req_ready), 32'd1);
		check_value("spec_valid", word_t'(spec_valid), 32'd0);
		check_value("resp_valid", word_t'(resp_valid), 32'd0);
		check_value("resp_confirm", word_t'(resp_confirm), 32'd0);
		check_value("resp_recover", word_t'(resp_recover), 32'd0);
		check_value("upd_en", word_t'(uut.upd_en), 32'd0);
		check_value("mem_req", word_t'(uut.mem_req), 32'd0);
		cfg_expect(CFG_CTRL, 32'd0, "cfg_rdata CTRL");
		cfg_expect(CFG_THRESH, 32'd2, "cfg_rdata THRESH");
		// prediction off, flags must stay low
		run_phase(100);
		check_counters();
		cfg_write(CFG_CTRL, 32'd1);
		model_enable = 1'b1;
		cfg_expect(CFG_CTRL, 32'd1, "cfg_rdata CTRL");
		run_phase(300);
		check_counters();
		// threshold 0, any valid entry speculates
		cfg_write(CFG_THRESH, 32'd0);
		model_thresh = 2'd0;
		cfg_expect(CFG_THRESH, 32'd0, "cfg_rdata THRESH");
		run_phase(300);
		check_counters();
		$display("TEST PASS");
		$finish;
	end

endmodule
